/* verilog.f */
mul_pkg.sv
mul_op_decode.sv
booth_pp_gen.sv
csa_tree.sv
mul_result.sv
mul_unit_top.sv
tb_mul_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the multiply unit testbench with Verilator.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	--top-module tb_mul_unit \
	-f verilog.f \
	-o Vtb_mul_unit

# The simulator exits non-zero on a failure; the log decides the outcome.
./obj_dir/Vtb_mul_unit > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "ALL CHECKS PASSED" "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

/* tb_mul_unit.sv */
`timescale 1ns/1ps

module tb_mul_unit;
	import mul_pkg::*;

	localparam int XLEN      = 64;
	localparam int N_CORNER  = 6;
	localparam int N_RAND_HI = 20;
	localparam int N_WORD    = 8;
	localparam int N_MIX     = 40;
	localparam int N_FLUSH   = 3;
	localparam int N_OPS     = 4 * N_CORNER * N_CORNER + 3 * N_RAND_HI + N_WORD + N_MIX + N_FLUSH;

	logic            clk;
	logic            rst_n;
	logic            in_valid;
	logic            flush;
	mul_op_e         op;
	logic            word;
	logic [XLEN-1:0] src_a;
	logic [XLEN-1:0] src_b;
	logic            out_valid;
	logic [XLEN-1:0] result;

	logic [15:0]     lfsr;
	logic [63:0]     cyc;
	logic [63:0]     exp_q [$];
	logic [63:0]     due_q [$];
	logic [63:0]     corner [N_CORNER];

	mul_unit_top #(.XLEN(XLEN)) i_mul_unit_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.flush     (flush),
		.op        (op),
		.word      (word),
		.src_a     (src_a),
		.src_b     (src_b),
		.out_valid (out_valid),
		.result    (result)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped after a failure");
	endtask

	task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
		if (got !== exp) begin
			$display("error at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	// feedback polynomial x^16 + x^14 + x^13 + x^11 + 1.
	// each call steps the register once and returns the new bit.
	function automatic logic rand_bit();
		logic fb;
		fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
		lfsr = {lfsr[14:0], fb};
		return fb;
	endfunction

	function automatic logic [63:0] rand64();
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < 64; i++) begin
			v = {v[62:0], rand_bit()};
		end
		return v;
	endfunction

	// multiplies both operands extended to 130 bits and returns the wanted part.
	function automatic logic [63:0] ref_product(input mul_op_e o, input logic w,
			input logic [63:0] a, input logic [63:0] b);
		logic [129:0] ax;
		logic [129:0] bx;
		logic [129:0] p;
		logic         sa;
		logic         sb;
		if (w) begin
			ax = {{98{a[31]}}, a[31:0]};
			bx = {{98{b[31]}}, b[31:0]};
			p  = ax * bx;
			return {{32{p[31]}}, p[31:0]};
		end
		sa = (o == MUL_OP_MUL) || (o == MUL_OP_MULH) || (o == MUL_OP_MULHSU);
		sb = (o == MUL_OP_MUL) || (o == MUL_OP_MULH);
		ax = sa ? {{66{a[63]}}, a} : {66'd0, a};
		bx = sb ? {{66{b[63]}}, b} : {66'd0, b};
		p  = ax * bx;
		return (o == MUL_OP_MUL) ? p[63:0] : p[127:64];
	endfunction

	// the DUT samples at the next edge and pulses two edges after that.
	task automatic issue_op(input mul_op_e o, input logic w, input logic [63:0] a,
			input logic [63:0] b, input logic dropped, input logic with_flush);
		@(posedge clk);
		in_valid <= 1'b1;
		flush    <= with_flush;
		op       <= o;
		word     <= w;
		src_a    <= a;
		src_b    <= b;
		if (!dropped) begin
			exp_q.push_back(ref_product(o, w, a, b));
			due_q.push_back(cyc + 64'd3);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid <= 1'b0;
			flush    <= 1'b0;
		end
	endtask

	task automatic drain_results();
		idle_cycles(1);
		while (exp_q.size() != 0) begin
			@(negedge clk);
		end
	endtask

	// every pulse must match the oldest outstanding operation and arrive on time.
	always @(negedge clk) begin
		cyc = cyc + 64'd1;
		if (rst_n && out_valid) begin
			if (exp_q.size() == 0) begin
				$display("result pulse at %0d ns with no operation outstanding", $time);
				abort_run();
			end else begin
				check_val(result, exp_q.pop_front(), "result value");
				check_val(cyc, due_q.pop_front(), "result arrival cycle");
			end
		end
	end

	task automatic idle_after_reset();
		repeat (8) begin
			@(negedge clk);
			check_val(64'(out_valid), 64'd0, "out_valid while idle");
		end
	endtask

	task automatic mul_corners();
		for (int i = 0; i < N_CORNER; i++) begin
			for (int j = 0; j < N_CORNER; j++) begin
				issue_op(MUL_OP_MUL, 1'b0, corner[i], corner[j], 1'b0, 1'b0);
			end
		end
		drain_results();
	endtask

	task automatic high_half_products();
		mul_op_e o;
		for (int k = 1; k <= 3; k++) begin
			o = mul_op_e'(k);
			for (int i = 0; i < N_CORNER; i++) begin
				for (int j = 0; j < N_CORNER; j++) begin
					issue_op(o, 1'b0, corner[i], corner[j], 1'b0, 1'b0);
				end
			end
			for (int n = 0; n < N_RAND_HI; n++) begin
				issue_op(o, 1'b0, rand64(), rand64(), 1'b0, 1'b0);
			end
		end
		drain_results();
	endtask

	task automatic word_products();
		// upper halves carry junk that must not reach the result.
		issue_op(MUL_OP_MUL, 1'b1, 64'hffff_ffff_7fff_ffff, 64'h0000_0000_0000_0002, 1'b0, 1'b0);
		issue_op(MUL_OP_MUL, 1'b1, 64'h1234_5678_8000_0000, 64'hdead_beef_ffff_ffff, 1'b0, 1'b0);
		for (int n = 2; n < N_WORD; n++) begin
			issue_op(MUL_OP_MUL, 1'b1, rand64(), rand64(), 1'b0, 1'b0);
		end
		drain_results();
	endtask

	task automatic mixed_back_to_back();
		logic    b1;
		logic    b0;
		logic    w;
		mul_op_e o;
		for (int n = 0; n < N_MIX; n++) begin
			b1 = rand_bit();
			b0 = rand_bit();
			w  = rand_bit();
			o  = mul_op_e'({1'b0, b1, b0});
			// word form exists only with the plain mul opcode.
			issue_op(o, w & (o == MUL_OP_MUL), rand64(), rand64(), 1'b0, 1'b0);
		end
		drain_results();
	endtask

	task automatic flush_in_flight();
		issue_op(MUL_OP_MULH, 1'b0, rand64(), rand64(), 1'b1, 1'b0);
		// second op arrives with flush, which also empties stage 1.
		issue_op(MUL_OP_MULHU, 1'b0, rand64(), rand64(), 1'b1, 1'b1);
		idle_cycles(4);
		issue_op(MUL_OP_MULHSU, 1'b0, rand64(), rand64(), 1'b0, 1'b0);
		drain_results();
	endtask

	initial begin
		#((N_OPS + 50) * 100);
		$display("simulation timed out before all tests finished");
		abort_run();
	end

	initial begin
		lfsr      = 16'd87;
		cyc       = 64'd0;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		flush     = 1'b0;
		op        = MUL_OP_MUL;
		word      = 1'b0;
		src_a     = '0;
		src_b     = '0;
		corner[0] = 64'h0000_0000_0000_0000;
		corner[1] = 64'h0000_0000_0000_0001;
		corner[2] = 64'hffff_ffff_ffff_ffff;
		corner[3] = 64'h8000_0000_0000_0000;
		corner[4] = 64'h7fff_ffff_ffff_ffff;
		corner[5] = 64'hdead_beef_0bad_f00d;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		idle_after_reset();
		mul_corners();
		high_half_products();
		word_products();
		mixed_back_to_back();
		flush_in_flight();
		idle_cycles(3);
		if (exp_q.size() != 0) begin
			$display("%0d results never arrived", exp_q.size());
			abort_run();
		end else begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

/* mul_unit_top.sv */
`timescale 1ns/1ps

module mul_unit_top #(
	parameter int XLEN = 64
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             in_valid,
	input  logic             flush,
	input  mul_pkg::mul_op_e op,
	input  logic             word,
	input  logic [XLEN-1:0]  src_a,
	input  logic [XLEN-1:0]  src_b,
	output logic             out_valid,
	output logic [XLEN-1:0]  result
);
	import mul_pkg::*;

	localparam int ROW_W = row_width(XLEN);
	localparam int PP_N  = pp_count(XLEN);

	logic             a_signed;
	logic             b_signed;
	logic             ext_word;
	logic             take_high;
	logic             word_res;
	logic [ROW_W-1:0] pp_rows [PP_N];
	logic [PP_N-1:0]  pp_neg;
	logic             pp_valid;
	logic [ROW_W-1:0] sum_row;
	logic [ROW_W-1:0] carry_row;
	logic             csa_valid;

	mul_op_decode i_decode (
		.op        (op),
		.word      (word),
		.a_signed  (a_signed),
		.b_signed  (b_signed),
		.ext_word  (ext_word),
		.take_high (take_high),
		.word_res  (word_res)
	);

	booth_pp_gen #(.XLEN(XLEN)) i_booth (
		.clk      (clk),
		.rst_n    (rst_n),
		.flush    (flush),
		.in_valid (in_valid),
		.a_signed (a_signed),
		.b_signed (b_signed),
		.ext_word (ext_word),
		.src_a    (src_a),
		.src_b    (src_b),
		.pp_rows  (pp_rows),
		.pp_neg   (pp_neg),
		.pp_valid (pp_valid)
	);

	csa_tree #(.XLEN(XLEN)) i_csa (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.pp_valid  (pp_valid),
		.pp_rows   (pp_rows),
		.pp_neg    (pp_neg),
		.sum_row   (sum_row),
		.carry_row (carry_row),
		.csa_valid (csa_valid)
	);

	mul_result #(.XLEN(XLEN)) i_result (
		.clk       (clk),
		.rst_n     (rst_n),
		.flush     (flush),
		.in_valid  (in_valid),
		.take_high (take_high),
		.word_res  (word_res),
		.csa_valid (csa_valid),
		.sum_row   (sum_row),
		.carry_row (carry_row),
		.out_valid (out_valid),
		.result    (result)
	);

	// mulw only exists with the mul funct3, the decoder has no high-half word form.
	a_word_low_only: assert property (@(posedge clk) disable iff (!rst_n)
		(in_valid && word) |-> (op == MUL_OP_MUL));

endmodule

/* mul_result.sv */
`timescale 1ns/1ps

module mul_result #(
	parameter int XLEN = 64
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 flush,
	input  logic                                 in_valid,
	input  logic                                 take_high,
	input  logic                                 word_res,
	input  logic                                 csa_valid,
	input  logic [mul_pkg::row_width(XLEN)-1:0]  sum_row,
	input  logic [mul_pkg::row_width(XLEN)-1:0]  carry_row,
	output logic                                 out_valid,
	output logic [XLEN-1:0]                      result
);
	import mul_pkg::*;

	localparam int ROW_W = row_width(XLEN);

	logic             s1_valid;
	logic             s1_high;
	logic             s1_word;
	logic             s2_high;
	logic             s2_word;
	logic [ROW_W-1:0] product;

	// sideband stage 1 lines up with the partial-product registers.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
		end else begin
			s1_valid <= in_valid & ~flush;
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			s1_high <= take_high;
			s1_word <= word_res;
		end
		// stage 2 lines up with the sum and carry rows.
		if (s1_valid) begin
			s2_high <= s1_high;
			s2_word <= s1_word;
		end
	end

	// final carry-propagate add.
	assign product = sum_row + carry_row;

	always_comb begin
		if (s2_word) begin
			result = XLEN'($signed(product[31:0]));
		end else if (s2_high) begin
			result = product[2*XLEN-1:XLEN];
		end else begin
			result = product[XLEN-1:0];
		end
	end

	assign out_valid = csa_valid;

	// both sideband stages and the rows are loaded whenever a result is presented.
	a_result_known: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> !$isunknown(result));

endmodule

/* csa_tree.sv */
`timescale 1ns/1ps

module csa_tree #(
	parameter int XLEN = 64
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 flush,
	input  logic                                 pp_valid,
	input  logic [mul_pkg::row_width(XLEN)-1:0]  pp_rows [mul_pkg::pp_count(XLEN)],
	input  logic [mul_pkg::pp_count(XLEN)-1:0]   pp_neg,
	output logic [mul_pkg::row_width(XLEN)-1:0]  sum_row,
	output logic [mul_pkg::row_width(XLEN)-1:0]  carry_row,
	output logic                                 csa_valid
);
	import mul_pkg::*;

	localparam int ROW_W = row_width(XLEN);
	localparam int PP_N  = pp_count(XLEN);
	// partial products plus one row of correction bits.
	localparam int N_IN  = PP_N + 1;
	// each 3:2 layer retires one input row.
	localparam int N_LAY = N_IN - 2;

	logic [ROW_W-1:0] in_rows [N_IN];

	// last input row collects the +1 corrections at each row's lsb weight.
	always_comb begin
		in_rows[PP_N] = '0;
		for (int i = 0; i < PP_N; i++) begin
			in_rows[i]          = pp_rows[i];
			in_rows[PP_N][2*i]  = pp_neg[i];
		end
	end

	// carry-save chain; layer k folds input row k+2 into the running pair.
	genvar k;
	generate
		for (k = 0; k < N_LAY; k++) begin : g_layer
			logic [ROW_W-1:0] s_in;
			logic [ROW_W-1:0] c_in;
			logic [ROW_W-1:0] x_in;
			logic [ROW_W-1:0] s_out;
			logic [ROW_W-1:0] c_out;

			if (k == 0) begin : g_first
				assign s_in = in_rows[0];
				assign c_in = in_rows[1];
			end else begin : g_next
				assign s_in = g_layer[k-1].s_out;
				assign c_in = g_layer[k-1].c_out;
			end

			assign x_in  = in_rows[k+2];
			assign s_out = s_in ^ c_in ^ x_in;
			// majority moves one weight up; the top carry falls off (mod 2^ROW_W).
			assign c_out = ((s_in & c_in) | (s_in & x_in) | (c_in & x_in)) << 1;
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (pp_valid) begin
			sum_row   <= g_layer[N_LAY-1].s_out;
			carry_row <= g_layer[N_LAY-1].c_out;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			csa_valid <= 1'b0;
		end else begin
			csa_valid <= pp_valid & ~flush;
		end
	end

	// a valid stage-2 entry holds rows built from known partial products.
	a_rows_known: assert property (@(posedge clk) disable iff (!rst_n)
		csa_valid |-> !$isunknown({sum_row, carry_row}));

endmodule

/* booth_pp_gen.sv */
`timescale 1ns/1ps

module booth_pp_gen #(
	parameter int XLEN = 64
) (
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 flush,
	input  logic                                 in_valid,
	input  logic                                 a_signed,
	input  logic                                 b_signed,
	input  logic                                 ext_word,
	input  logic [XLEN-1:0]                      src_a,
	input  logic [XLEN-1:0]                      src_b,
	output logic [mul_pkg::row_width(XLEN)-1:0]  pp_rows [mul_pkg::pp_count(XLEN)],
	output logic [mul_pkg::pp_count(XLEN)-1:0]   pp_neg,
	output logic                                 pp_valid
);
	import mul_pkg::*;

	localparam int EXT_W = ext_width(XLEN);
	localparam int ROW_W = row_width(XLEN);
	localparam int PP_N  = pp_count(XLEN);

	logic [EXT_W-1:0] a_ext;
	logic [EXT_W-1:0] b_ext;
	logic [EXT_W:0]   a_pad;
	logic [ROW_W-1:0] b_row;
	logic [ROW_W-1:0] pp_d [PP_N];
	logic [PP_N-1:0]  neg_d;

	// two-bit extension of an operand; word mode fills the upper half from bit 31.
	function automatic logic [EXT_W-1:0] extend_op(
		input logic [XLEN-1:0] v,
		input logic            sgn,
		input logic            w
	);
		logic             msb;
		logic [EXT_W-1:0] r;
		msb = sgn & (w ? v[31] : v[XLEN-1]);
		r   = {{2{msb}}, v};
		if (w) begin
			r[EXT_W-1:32] = {(EXT_W-32){msb}};
		end
		return r;
	endfunction

	assign a_ext = extend_op(src_a, a_signed, ext_word);
	assign b_ext = extend_op(src_b, b_signed, ext_word);

	// implicit zero below the lsb starts the first window.
	assign a_pad = {a_ext, 1'b0};
	assign b_row = {{(ROW_W-EXT_W){b_ext[EXT_W-1]}}, b_ext};

	// radix-4 recoding, window i covers a_pad[2i+2:2i].
	always_comb begin
		logic [2:0]       win;
		logic [ROW_W-1:0] mag;
		for (int i = 0; i < PP_N; i++) begin
			win = a_pad[2*i +: 3];
			case (win)
				3'b001, 3'b010, 3'b101, 3'b110: mag = b_row;
				3'b011, 3'b100:                 mag = b_row << 1;
				default:                        mag = '0;
			endcase
			// 111 is a zero digit, so it gets no inversion.
			neg_d[i] = win[2] & ~(win[1] & win[0]);
			// the +1 of the two's complement goes out as pp_neg at weight 2i.
			pp_d[i] = (neg_d[i] ? ~mag : mag) << (2 * i);
		end
	end

	always_ff @(posedge clk) begin
		if (in_valid) begin
			pp_rows <= pp_d;
			pp_neg  <= neg_d;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pp_valid <= 1'b0;
		end else begin
			pp_valid <= in_valid & ~flush;
		end
	end

	// operands feed straight into the recoder, so they must be known when issued.
	a_known_operands: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !$isunknown({src_a, src_b}));

endmodule

/* mul_op_decode.sv */
`timescale 1ns/1ps

module mul_op_decode (
	input  mul_pkg::mul_op_e op,
	input  logic             word,
	output logic             a_signed,
	output logic             b_signed,
	output logic             ext_word,
	output logic             take_high,
	output logic             word_res
);
	import mul_pkg::*;

	// operand signedness and half select per opcode.
	always_comb begin
		a_signed  = 1'b0;
		b_signed  = 1'b0;
		take_high = 1'b0;
		case (op)
			MUL_OP_MUL: begin
				a_signed = 1'b1;
				b_signed = 1'b1;
			end
			MUL_OP_MULH: begin
				a_signed  = 1'b1;
				b_signed  = 1'b1;
				take_high = 1'b1;
			end
			MUL_OP_MULHSU: begin
				// rs1 signed, rs2 unsigned.
				a_signed  = 1'b1;
				take_high = 1'b1;
			end
			MUL_OP_MULHU: begin
				take_high = 1'b1;
			end
			default: begin
				take_high = 1'b0;
			end
		endcase

		// mulw works on the signed low words and keeps the low half.
		if (word) begin
			a_signed  = 1'b1;
			b_signed  = 1'b1;
			take_high = 1'b0;
		end
	end

	// extension stage replicates bit 31 upward in word mode.
	assign ext_word = word;

	// result stage sign-extends the low 32 bits in word mode.
	assign word_res = word;

endmodule

/* mul_pkg.sv */
package mul_pkg;

	// multiply opcodes, encoded as the RISC-V funct3 of the M extension.
	typedef enum logic [2:0] {
		MUL_OP_MUL    = 3'd0,
		MUL_OP_MULH   = 3'd1,
		MUL_OP_MULHSU = 3'd2,
		MUL_OP_MULHU  = 3'd3
	} mul_op_e;

	// number of radix-4 Booth partial products for an operand width.
	// the extra row absorbs the top digit of the two-bit extension.
	function automatic int pp_count(input int width);
		return width / 2 + 1;
	endfunction

	// operand width after sign or zero extension by two bits.
	function automatic int ext_width(input int width);
		return width + 2;
	endfunction

	// width of one partial-product row, wide enough for the full
	// product of two extended operands.
	function automatic int row_width(input int width);
		return 2 * width + 4;
	endfunction

endpackage
